//--- common/music_game_pkg.sv
package music_game_pkg;

    // Keyboard and song
    localparam int NUM_KEYS = 13;
    localparam int NOTE_W   = 4;
    localparam int SONG_LEN = 8;
    localparam int ADDR_W   = 3;

    // Beat timing kept short for simulation
    localparam int BEAT_TICKS    = 16;
    localparam int TIMEOUT_BEATS = 4;
    localparam int TICK_W        = $clog2(BEAT_TICKS);
    localparam int BEAT_CNT_W    = $clog2(TIMEOUT_BEATS);

    // Game rules
    localparam int MAX_ERRORS = 3;
    localparam int ERR_W      = 2;

    // Buzzer half-period in cycles for note 0
    localparam int TONE_BASE_HALF = 3;

    typedef logic [NOTE_W-1:0] note_t;

    typedef enum logic [3:0] {
        IDLE,
        PRESENT_NOTE,
        PRESENT_GAP,
        WAIT_PRESS,
        CHECK,
        NEXT_ROUND,
        ERROR_REPLAY,
        WON,
        LOST
    } game_state_t;

    // Strobes and levels from the FSM
    typedef struct packed {
        logic clear_addr;
        logic inc_addr;
        logic clear_round;
        logic inc_round;
        logic clear_errors;
        logic count_error;
        logic restart_timer;
        logic timer_enable;
        logic show_note;
    } ctrl_t;

    // Conditions back to the FSM
    typedef struct packed {
        logic addr_eq_round;
        logic last_round;
        logic press_seen;
        logic note_ok;
        logic errors_full;
        logic beat_end;
        logic timeout;
    } status_t;

endpackage

//--- source/song_rom.sv
module song_rom (
    input  logic [music_game_pkg::ADDR_W-1:0] addr,
    output music_game_pkg::note_t             note
);
    import music_game_pkg::*;

    // Ascending scale on the 13 keys
    always_comb begin
        case (addr)
            ADDR_W'(0): begin
                note = NOTE_W'(0);
            end
            ADDR_W'(1): begin
                note = NOTE_W'(2);
            end
            ADDR_W'(2): begin
                note = NOTE_W'(4);
            end
            ADDR_W'(3): begin
                note = NOTE_W'(5);
            end
            ADDR_W'(4): begin
                note = NOTE_W'(7);
            end
            ADDR_W'(5): begin
                note = NOTE_W'(9);
            end
            ADDR_W'(6): begin
                note = NOTE_W'(11);
            end
            default: begin
                note = NOTE_W'(12);
            end
        endcase
    end

endmodule

//--- source/beat_timer.sv
module beat_timer (
    input  logic                  clock,
    input  logic                  reset,
    input  music_game_pkg::ctrl_t ctrl,
    output logic                  beat_end,
    output logic                  timeout
);
    import music_game_pkg::*;

    logic [TICK_W-1:0]     tick_count;
    logic [BEAT_CNT_W-1:0] beat_count;

    // Last tick of the current beat
    assign beat_end = ctrl.timer_enable && (tick_count == TICK_W'(BEAT_TICKS - 1));

    // Fires on the beat that completes the reply window
    assign timeout = beat_end && (beat_count == BEAT_CNT_W'(TIMEOUT_BEATS - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            tick_count <= '0;
        end else if (ctrl.restart_timer) begin
            tick_count <= '0;
        end else if (ctrl.timer_enable) begin
            if (beat_end) begin
                tick_count <= '0;
            end else begin
                tick_count <= tick_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            beat_count <= '0;
        end else if (ctrl.restart_timer) begin
            beat_count <= '0;
        end else if (timeout) begin
            beat_count <= '0;
        end else if (beat_end) begin
            beat_count <= beat_count + 1'b1;
        end
    end

endmodule

//--- source/play_checker.sv
module play_checker (
    input  logic                                clock,
    input  logic                                reset,
    input  music_game_pkg::ctrl_t               ctrl,
    input  logic [music_game_pkg::NUM_KEYS-1:0] botoes,
    input  music_game_pkg::note_t               expected,
    input  logic                                vez_jogador,
    output logic [music_game_pkg::ADDR_W-1:0]   addr,
    output logic [music_game_pkg::NUM_KEYS-1:0] leds,
    output logic [music_game_pkg::ERR_W-1:0]    erros,
    output logic                                press_seen,
    output logic                                note_ok,
    output logic                                addr_eq_round,
    output logic                                last_round,
    output logic                                errors_full
);
    import music_game_pkg::*;

    logic [ADDR_W-1:0]   round;
    logic [NUM_KEYS-1:0] botoes_q;
    logic                press_edge;
    logic                single_key;
    note_t               pressed_note;

    assign addr_eq_round = (addr == round);
    assign last_round    = (round == ADDR_W'(SONG_LEN - 1));
    assign errors_full   = (erros == ERR_W'(MAX_ERRORS));

    // New press only after all keys were released
    assign press_edge = (botoes != '0) && (botoes_q == '0);
    assign single_key = ((botoes & (botoes - 1'b1)) == '0);

    // Lowest pressed key gives the note
    always_comb begin
        pressed_note = '0;
        for (int i = NUM_KEYS - 1; i >= 0; i--) begin
            if (botoes[i]) begin
                pressed_note = NOTE_W'(i);
            end
        end
    end

    always_comb begin
        if (ctrl.show_note) begin
            leds = NUM_KEYS'(1) << expected;
        end else if (vez_jogador) begin
            leds = botoes;
        end else begin
            leds = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            addr       <= '0;
            round      <= '0;
            erros      <= '0;
            botoes_q   <= '0;
            press_seen <= 1'b0;
        end else begin
            botoes_q   <= botoes;
            press_seen <= press_edge && vez_jogador;
            if (ctrl.clear_addr) begin
                addr <= '0;
            end else if (ctrl.inc_addr) begin
                addr <= addr + 1'b1;
            end
            if (ctrl.clear_round) begin
                round <= '0;
            end else if (ctrl.inc_round) begin
                round <= round + 1'b1;
            end
            if (ctrl.clear_errors) begin
                erros <= '0;
            end else if (ctrl.count_error && !errors_full) begin
                erros <= erros + 1'b1;
            end
        end
    end

    // Held until the next press so CHECK can read it
    always_ff @(posedge clock) begin
        if (press_edge) begin
            note_ok <= single_key && (pressed_note == expected);
        end
    end

endmodule

//--- source/tone_generator.sv
module tone_generator (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  enable,
    input  music_game_pkg::note_t note,
    output logic                  pulso_buzzer
);
    import music_game_pkg::*;

    logic [NOTE_W:0] half_period;
    logic [NOTE_W:0] count;
    logic            tone_q;

    // Higher notes get longer half-periods
    assign half_period = (NOTE_W + 1)'(TONE_BASE_HALF) + {1'b0, note};

    // Silent at once when the note goes dark
    assign pulso_buzzer = enable && tone_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            count  <= '0;
            tone_q <= 1'b0;
        end else if (!enable) begin
            count  <= '0;
            tone_q <= 1'b0;
        end else if (count == half_period - 1'b1) begin
            count  <= '0;
            tone_q <= ~tone_q;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

//--- control/game_control.sv
module game_control (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    iniciar,
    input  music_game_pkg::status_t status,
    output music_game_pkg::ctrl_t   ctrl,
    output logic                    ganhou,
    output logic                    perdeu,
    output logic                    vez_jogador
);
    import music_game_pkg::*;

    game_state_t state;
    game_state_t next_state;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign ganhou      = (state == WON);
    assign perdeu      = (state == LOST);
    assign vez_jogador = (state == WAIT_PRESS) || (state == CHECK);

    always_comb begin
        next_state = state;
        ctrl       = '0;
        case (state)
            IDLE, WON, LOST: begin
                // New game from any resting state
                if (iniciar) begin
                    ctrl.clear_addr    = 1'b1;
                    ctrl.clear_round   = 1'b1;
                    ctrl.clear_errors  = 1'b1;
                    ctrl.restart_timer = 1'b1;
                    next_state         = PRESENT_NOTE;
                end
            end
            PRESENT_NOTE: begin
                ctrl.timer_enable = 1'b1;
                ctrl.show_note    = 1'b1;
                if (status.beat_end) begin
                    next_state = PRESENT_GAP;
                end
            end
            PRESENT_GAP: begin
                ctrl.timer_enable = 1'b1;
                if (status.beat_end) begin
                    if (status.addr_eq_round) begin
                        ctrl.clear_addr    = 1'b1;
                        ctrl.restart_timer = 1'b1;
                        next_state         = WAIT_PRESS;
                    end else begin
                        ctrl.inc_addr = 1'b1;
                        next_state    = PRESENT_NOTE;
                    end
                end
            end
            WAIT_PRESS: begin
                ctrl.timer_enable = 1'b1;
                if (status.press_seen) begin
                    ctrl.restart_timer = 1'b1;
                    next_state         = CHECK;
                end else if (status.timeout) begin
                    ctrl.count_error   = 1'b1;
                    ctrl.restart_timer = 1'b1;
                    next_state         = ERROR_REPLAY;
                end
            end
            CHECK: begin
                ctrl.timer_enable = 1'b1;
                if (!status.note_ok) begin
                    ctrl.count_error   = 1'b1;
                    ctrl.restart_timer = 1'b1;
                    next_state         = ERROR_REPLAY;
                end else if (!status.addr_eq_round) begin
                    ctrl.inc_addr = 1'b1;
                    next_state    = WAIT_PRESS;
                end else if (status.last_round) begin
                    next_state = WON;
                end else begin
                    ctrl.restart_timer = 1'b1;
                    next_state         = NEXT_ROUND;
                end
            end
            NEXT_ROUND: begin
                // One dark beat before the longer round
                ctrl.timer_enable = 1'b1;
                if (status.beat_end) begin
                    ctrl.inc_round  = 1'b1;
                    ctrl.clear_addr = 1'b1;
                    next_state      = PRESENT_NOTE;
                end
            end
            ERROR_REPLAY: begin
                ctrl.timer_enable = 1'b1;
                if (status.errors_full) begin
                    next_state = LOST;
                end else if (status.beat_end) begin
                    ctrl.clear_addr = 1'b1;
                    next_state      = PRESENT_NOTE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

//--- source/music_game.sv
module music_game (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                iniciar,
    input  logic [music_game_pkg::NUM_KEYS-1:0] botoes,
    output logic                                ganhou,
    output logic                                perdeu,
    output logic                                vez_jogador,
    output logic [music_game_pkg::NUM_KEYS-1:0] leds,
    output logic                                pulso_buzzer,
    output logic [music_game_pkg::ERR_W-1:0]    db_erros
);
    import music_game_pkg::*;

    ctrl_t             ctrl;
    status_t           status;
    logic [ADDR_W-1:0] addr;
    note_t             song_note;

    game_control game_control_inst (
        .clock       ( clock       ),
        .reset       ( reset       ),
        .iniciar     ( iniciar     ),
        .status      ( status      ),
        .ctrl        ( ctrl        ),
        .ganhou      ( ganhou      ),
        .perdeu      ( perdeu      ),
        .vez_jogador ( vez_jogador )
    );

    beat_timer beat_timer_inst (
        .clock    ( clock           ),
        .reset    ( reset           ),
        .ctrl     ( ctrl            ),
        .beat_end ( status.beat_end ),
        .timeout  ( status.timeout  )
    );

    // Data side fills the remaining status fields
    play_checker play_checker_inst (
        .clock         ( clock                ),
        .reset         ( reset                ),
        .ctrl          ( ctrl                 ),
        .botoes        ( botoes               ),
        .expected      ( song_note            ),
        .vez_jogador   ( vez_jogador          ),
        .addr          ( addr                 ),
        .leds          ( leds                 ),
        .erros         ( db_erros             ),
        .press_seen    ( status.press_seen    ),
        .note_ok       ( status.note_ok       ),
        .addr_eq_round ( status.addr_eq_round ),
        .last_round    ( status.last_round    ),
        .errors_full   ( status.errors_full   )
    );

    song_rom song_rom_inst (
        .addr ( addr      ),
        .note ( song_note )
    );

    tone_generator tone_generator_inst (
        .clock        ( clock          ),
        .reset        ( reset          ),
        .enable       ( ctrl.show_note ),
        .note         ( song_note      ),
        .pulso_buzzer ( pulso_buzzer   )
    );

endmodule

//--- dv/music_game_tb.sv
module music_game_tb;
    import music_game_pkg::*;

    localparam int TRACE_DEPTH = 80;

    typedef enum int {
        LEDS_ON,
        TURN_ON,
        TURN_OFF,
        WON_SEEN,
        LOST_SEEN,
        ERRORS_MATCH
    } wait_cond_t;

    logic                clock;
    logic                reset;
    logic                iniciar;
    logic [NUM_KEYS-1:0] botoes;
    logic                ganhou;
    logic                perdeu;
    logic                vez_jogador;
    logic [NUM_KEYS-1:0] leds;
    logic                pulso_buzzer;
    logic [ERR_W-1:0]    db_erros;

    logic [7:0] trace_mem [0:TRACE_DEPTH-1];
    int         round_num;
    int         error_count;
    int         fail_count;
    int         test_count;

    music_game music_game_inst (
        .clock        ( clock        ),
        .reset        ( reset        ),
        .iniciar      ( iniciar      ),
        .botoes       ( botoes       ),
        .ganhou       ( ganhou       ),
        .perdeu       ( perdeu       ),
        .vez_jogador  ( vez_jogador  ),
        .leds         ( leds         ),
        .pulso_buzzer ( pulso_buzzer ),
        .db_erros     ( db_erros     )
    );

    initial begin
        clock = 1'b0;
        forever begin
            #10 clock = ~clock;
        end
    end

    function automatic logic [NUM_KEYS-1:0] key_pattern(int key);
        logic [NUM_KEYS-1:0] pattern;
        pattern      = '0;
        pattern[key] = 1'b1;
        return pattern;
    endfunction

    // Song notes sit at the head of the trace
    function automatic int song_note(int idx);
        return int'(trace_mem[idx]);
    endfunction

    function automatic logic cond_met(wait_cond_t cond);
        case (cond)
            LEDS_ON:   return leds != '0;
            TURN_ON:   return vez_jogador;
            TURN_OFF:  return !vez_jogador;
            WON_SEEN:  return ganhou;
            LOST_SEEN: return perdeu;
            default:   return db_erros == ERR_W'(error_count);
        endcase
    endfunction

    task automatic wait_until(wait_cond_t cond, int limit, string what);
        int n;
        n = 0;
        while (!cond_met(cond) && n < limit) begin
            @(negedge clock);
            n++;
        end
        if (!cond_met(cond)) begin
            $display("Timed out after %0d cycles waiting for %s", limit, what);
            $display("Some tests failed");
            $finish;
        end
    endtask

    // Random release gap, then one press
    task automatic press_key(logic [NUM_KEYS-1:0] pattern, int hold);
        int gap;
        gap = 2 + int'($urandom % 16);
        repeat (gap) @(negedge clock);
        @(posedge clock);
        botoes <= pattern;
        repeat (hold) @(posedge clock);
        botoes <= '0;
        // Press is acted on by the third edge after it
        if (hold < 3) begin
            repeat (3 - hold) @(posedge clock);
        end
        @(negedge clock);
    endtask

    task automatic check_presentation(int r);
        int   half;
        logic tone;
        wait_until(LEDS_ON, 3 * BEAT_TICKS, "the first presented note");
        for (int i = 0; i <= r; i++) begin
            half = TONE_BASE_HALF + song_note(i);
            for (int k = 0; k < BEAT_TICKS; k++) begin
                tone = ((k / half) % 2) == 1;
                assert (leds == key_pattern(song_note(i)) && pulso_buzzer == tone) else begin
                    fail_count++;
                    $display("[FAIL] %0t: round %0d note %0d cycle %0d, leds %h buzzer %b",
                             $time, r, i, k, leds, pulso_buzzer);
                end
                @(negedge clock);
            end
            for (int k = 0; k < BEAT_TICKS; k++) begin
                assert (leds == '0 && !pulso_buzzer && !vez_jogador) else begin
                    fail_count++;
                    $display("[FAIL] %0t: gap after note %0d not dark, leds %h", $time, i, leds);
                end
                @(negedge clock);
            end
        end
        assert (vez_jogador) else begin
            fail_count++;
            $display("[FAIL] %0t: player turn missing after round %0d", $time, r);
        end
    endtask

    task automatic play_prefix(int count, int hold);
        for (int i = 0; i < count; i++) begin
            press_key(key_pattern(song_note(i)), hold);
            assert (vez_jogador && db_erros == ERR_W'(error_count)) else begin
                fail_count++;
                $display("[FAIL] %0t: turn lost after correct note %0d of round %0d",
                         $time, i, round_num);
            end
        end
    endtask

    task automatic finish_error(int limit);
        error_count++;
        wait_until(ERRORS_MATCH, limit, "the error count to rise");
        if (error_count >= MAX_ERRORS) begin
            wait_until(LOST_SEEN, 8, "perdeu");
            assert (!vez_jogador && !ganhou) else begin
                fail_count++;
                $display("[FAIL] %0t: lost game still shows turn or win", $time);
            end
        end else begin
            wait_until(TURN_OFF, 8, "the end of the player turn");
            check_presentation(round_num);
        end
    endtask

    task automatic start_game();
        @(posedge clock);
        iniciar <= 1'b1;
        @(posedge clock);
        iniciar <= 1'b0;
        @(negedge clock);
        error_count = 0;
        round_num   = 0;
        assert (db_erros == '0 && !ganhou && !perdeu) else begin
            fail_count++;
            $display("[FAIL] %0t: new game kept errors %0d or end flags", $time, db_erros);
        end
        check_presentation(0);
    endtask

    task automatic play_round(int hold);
        wait_until(TURN_ON, 4, "the player turn");
        play_prefix(round_num, hold);
        press_key(key_pattern(song_note(round_num)), hold);
        if (round_num == SONG_LEN - 1) begin
            wait_until(WON_SEEN, 8, "ganhou");
            assert (!vez_jogador && !perdeu && db_erros == ERR_W'(error_count)) else begin
                fail_count++;
                $display("[FAIL] %0t: won game with bad outputs", $time);
            end
        end else begin
            wait_until(TURN_OFF, 8, "the end of the player turn");
            assert (db_erros == ERR_W'(error_count)) else begin
                fail_count++;
                $display("[FAIL] %0t: errors %0d after correct round", $time, db_erros);
            end
            round_num++;
            check_presentation(round_num);
        end
    endtask

    task automatic wrong_key_round(int key, int hold);
        wait_until(TURN_ON, 4, "the player turn");
        play_prefix(round_num, hold);
        press_key(key_pattern(key), hold);
        finish_error(8);
    endtask

    task automatic silent_round(int hold);
        wait_until(TURN_ON, 4, "the player turn");
        play_prefix(round_num, hold);
        // Too early for the timeout
        repeat ((TIMEOUT_BEATS - 1) * BEAT_TICKS) begin
            assert (vez_jogador && db_erros == ERR_W'(error_count)) else begin
                fail_count++;
                $display("[FAIL] %0t: early timeout in round %0d", $time, round_num);
            end
            @(negedge clock);
        end
        finish_error(2 * BEAT_TICKS);
    endtask

    task automatic end_test(string name, int fails_before);
        test_count++;
        $display("test %0d %s: %s", test_count, name,
                 (fail_count == fails_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int         rec;
        int         hold;
        int         fails_before;
        logic [7:0] key;
        logic [7:0] tag;
        string      name;

        void'($urandom(16956));
        reset       = 1'b1;
        iniciar     = 1'b0;
        botoes      = '0;
        fail_count  = 0;
        test_count  = 0;
        error_count = 0;
        round_num   = 0;
        $readmemh("dv/music_game_trace.txt", trace_mem);

        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        assert (!ganhou && !perdeu && !vez_jogador && !pulso_buzzer && leds == '0) else begin
            fail_count++;
            $display("[FAIL] %0t: outputs not idle after reset", $time);
        end
        end_test("outputs after reset", 0);

        rec = SONG_LEN;
        while (rec + 2 < TRACE_DEPTH && trace_mem[rec + 2] != 8'h0f) begin
            key          = trace_mem[rec];
            hold         = (trace_mem[rec + 1] == 8'h00) ? 1 : int'(trace_mem[rec + 1]);
            tag          = trace_mem[rec + 2];
            fails_before = fail_count;
            case (tag)
                8'h00: begin
                    name = $sformatf("round %0d played", round_num);
                    play_round(hold);
                end
                8'h01: begin
                    name = $sformatf("round %0d wrong key %0d", round_num, key);
                    wrong_key_round(int'(key), hold);
                end
                8'h02: begin
                    name = $sformatf("round %0d without presses", round_num);
                    silent_round(hold);
                end
                8'h03: begin
                    name = "new game";
                    start_game();
                end
                default: begin
                    name = $sformatf("unknown trace tag %h", tag);
                    fail_count++;
                    $display("Trace entry %0d holds an unknown tag %h", rec + 2, tag);
                end
            endcase
            end_test(name, fails_before);
            rec += 3;
        end

        $display("%0d tests run, %0d checks failed", test_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- dv/music_game_trace.txt
// First line holds the eight song notes, then each record is key hold tag
// Tags are 0 correct round, 1 wrong key on last note, 2 no press, 3 new game, f end
0 2 4 5 7 9 b c
0 0 3
0 3 0
0 4 0
9 2 1
0 2 2
0 5 0
0 3 2
0 0 3
0 2 0
0 1 0
0 4 0
0 3 0
0 2 0
0 6 0
0 2 0
0 3 0
0 0 f

//--- music_game.f
common/music_game_pkg.sv
source/song_rom.sv
source/beat_timer.sv
source/play_checker.sv
source/tone_generator.sv
control/game_control.sv
source/music_game.sv
dv/music_game_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= music_game_tb
RTL_TOP    ?= music_game
FILELIST   ?= music_game.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
